//--- Bender.yml
package:
  name: dcache

sources:
  - dcache_mem_pkg.sv
  - dcache_cpu_pkg.sv
  - word_lane_adapter.sv
  - dcache_arrays.sv
  - dcache_controller.sv
  - cacheline_adaptor.sv
  - dcache_top.sv
  - target: simulation
    files:
      - tb_bmem_model.sv
      - tb_dcache_top.sv

//--- cacheline_adaptor.sv
`default_nettype none
`timescale 1ns/10ps

module cacheline_adaptor (
    input  wire                                clk,
    input  wire                                rst,
    input  wire dcache_mem_pkg::line_req_t     line_req_i,
    output dcache_mem_pkg::line_t              line_o,
    output logic                               line_resp_o,
    output dcache_mem_pkg::bmem_req_t          bmem_req_o,
    input  wire dcache_mem_pkg::burst_t        bmem_rdata_i,
    input  wire                                bmem_resp_i
);

    localparam int LINE_W  = $bits(dcache_mem_pkg::line_t);
    localparam int BURST_W = $bits(dcache_mem_pkg::burst_t);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        DONE
    } state_e;

    state_e                     state_q;
    state_e                     state_d;
    dcache_mem_pkg::beat_idx_t  beat_q;     // beat number on the bus
    dcache_mem_pkg::line_t      line_q;     // read beats collect here
    logic                       busy;
    logic                       last_beat;

    assign busy      = (state_q == READ) || (state_q == WRITE);
    assign last_beat = bmem_resp_i &&
                       (beat_q == dcache_mem_pkg::beat_idx_t'(dcache_mem_pkg::BURSTS_PER_LINE - 1));

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (line_req_i.read) begin
                    state_d = READ;
                end else if (line_req_i.write) begin
                    state_d = WRITE;
                end
            end
            READ, WRITE: begin
                if (last_beat) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;                 // line_resp for one cycle
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (busy && bmem_resp_i) begin
                beat_q <= beat_q + 1'b1;        // wraps to zero after the fourth beat
            end
        end
    end

    // lowest beat first, so shift in from the top
    always_ff @(posedge clk) begin
        if ((state_q == READ) && bmem_resp_i) begin
            line_q <= {bmem_rdata_i, line_q[LINE_W-1:BURST_W]};
        end
    end

    assign bmem_req_o.addr  = line_req_i.addr;
    assign bmem_req_o.read  = (state_q == READ);
    assign bmem_req_o.write = (state_q == WRITE);
    assign bmem_req_o.wdata = line_req_i.wdata[{beat_q, 6'b000000} +: BURST_W];

    assign line_o      = line_q;
    assign line_resp_o = (state_q == DONE);

endmodule : cacheline_adaptor

`default_nettype wire

//--- dcache.f
dcache_mem_pkg.sv
dcache_cpu_pkg.sv
word_lane_adapter.sv
dcache_arrays.sv
dcache_controller.sv
cacheline_adaptor.sv
dcache_top.sv
tb_bmem_model.sv
tb_dcache_top.sv

//--- dcache_arrays.sv
`default_nettype none
`timescale 1ns/10ps

module dcache_arrays #(
    parameter  int NUM_SETS_LOG2 = 3,
    localparam int TAG_W         = 32 - dcache_mem_pkg::LINE_OFFSET_BITS - NUM_SETS_LOG2
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire [NUM_SETS_LOG2-1:0]            index_i,
    input  wire [TAG_W-1:0]                    tag_i,
    input  wire                                write_line_i,
    input  wire dcache_mem_pkg::line_mask_t    line_mask_i,
    input  wire dcache_mem_pkg::line_t         line_wdata_i,
    input  wire                                set_valid_i,     // also writes the tag
    input  wire                                set_dirty_i,
    input  wire                                clear_dirty_i,
    output logic [TAG_W-1:0]                   tag_o,
    output logic                               valid_o,
    output logic                               dirty_o,
    output dcache_mem_pkg::line_t              line_o
);

    localparam int NUM_SETS = 2**NUM_SETS_LOG2;

    logic [TAG_W-1:0]       tag_mem  [NUM_SETS];
    dcache_mem_pkg::line_t  line_mem [NUM_SETS];
    logic [NUM_SETS-1:0]    valid_q;
    logic [NUM_SETS-1:0]    dirty_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (set_valid_i) begin
            valid_q[index_i] <= 1'b1;
        end
    end

    // set by a write hit and cleared by a fill
    always_ff @(posedge clk) begin
        if (set_dirty_i) begin
            dirty_q[index_i] <= 1'b1;
        end else if (clear_dirty_i) begin
            dirty_q[index_i] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (set_valid_i) begin
            tag_mem[index_i] <= tag_i;              // new tag on fill
        end
    end

    // byte-enabled line write, full mask on a fill
    always_ff @(posedge clk) begin
        if (write_line_i) begin
            for (int b = 0; b < $bits(dcache_mem_pkg::line_mask_t); b++) begin
                if (line_mask_i[b]) begin
                    line_mem[index_i][8*b +: 8] <= line_wdata_i[8*b +: 8];
                end
            end
        end
    end

    // read side is combinational at the current index
    assign tag_o   = tag_mem[index_i];
    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];
    assign line_o  = line_mem[index_i];

endmodule : dcache_arrays

`default_nettype wire

//--- dcache_controller.sv
`default_nettype none
`timescale 1ns/10ps

module dcache_controller #(
    parameter  int NUM_SETS_LOG2 = 3,
    localparam int TAG_W         = 32 - dcache_mem_pkg::LINE_OFFSET_BITS - NUM_SETS_LOG2
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire dcache_cpu_pkg::cpu_req_t      req_i,
    input  wire dcache_mem_pkg::line_t         lane_wdata_i,
    input  wire dcache_mem_pkg::line_mask_t    lane_mask_i,
    input  wire [TAG_W-1:0]                    tag_i,
    input  wire                                valid_i,
    input  wire                                dirty_i,
    input  wire dcache_mem_pkg::line_t         line_i,
    output logic [NUM_SETS_LOG2-1:0]           index_o,
    output logic [TAG_W-1:0]                   tag_o,
    output logic                               write_line_o,
    output dcache_mem_pkg::line_mask_t         line_mask_o,
    output dcache_mem_pkg::line_t              line_wdata_o,
    output logic                               set_valid_o,
    output logic                               set_dirty_o,
    output logic                               clear_dirty_o,
    output dcache_mem_pkg::line_req_t          line_req_o,
    input  wire dcache_mem_pkg::line_t         line_rdata_i,
    input  wire                                line_resp_i,
    output logic                               resp_o
);

    localparam int OFS_BITS = dcache_mem_pkg::LINE_OFFSET_BITS;

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITE_BACK,
        ALLOCATE,
        RESPOND
    } state_e;

    state_e            state_q;
    state_e            state_d;
    logic [TAG_W-1:0]  req_tag;
    logic              hit;

    assign index_o = req_i.addr[OFS_BITS +: NUM_SETS_LOG2];
    assign req_tag = req_i.addr[31 -: TAG_W];
    assign tag_o   = req_tag;                       // only written on a fill
    assign hit     = valid_i && (tag_i == req_tag);
    assign resp_o  = (state_q == RESPOND);          // one cycle, then back to idle

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d       = state_q;
        write_line_o  = 1'b0;
        line_mask_o   = '0;
        line_wdata_o  = lane_wdata_i;
        set_valid_o   = 1'b0;
        set_dirty_o   = 1'b0;
        clear_dirty_o = 1'b0;
        line_req_o    = '0;

        unique case (state_q)
            IDLE: begin
                if (req_i.read || req_i.write) begin
                    state_d = COMPARE;
                end
            end
            COMPARE: begin
                if (hit) begin
                    if (req_i.write) begin                  // merge lane into line
                        write_line_o = 1'b1;
                        line_mask_o  = lane_mask_i;
                        set_dirty_o  = 1'b1;
                    end
                    state_d = RESPOND;
                end else if (valid_i && dirty_i) begin
                    state_d = WRITE_BACK;
                end else begin
                    state_d = ALLOCATE;
                end
            end
            WRITE_BACK: begin
                // victim keeps its own tag, same index
                line_req_o.addr  = {tag_i, index_o, {OFS_BITS{1'b0}}};
                line_req_o.wdata = line_i;
                line_req_o.write = 1'b1;
                if (line_resp_i) begin
                    state_d = ALLOCATE;
                end
            end
            ALLOCATE: begin
                line_req_o.addr = {req_tag, index_o, {OFS_BITS{1'b0}}};
                line_req_o.read = 1'b1;
                if (line_resp_i) begin
                    write_line_o  = 1'b1;                   // install the whole line
                    line_mask_o   = '1;
                    line_wdata_o  = line_rdata_i;
                    set_valid_o   = 1'b1;
                    clear_dirty_o = 1'b1;
                    state_d       = COMPARE;                // retry now hits
                end
            end
            RESPOND: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule : dcache_controller

`default_nettype wire

//--- dcache_cpu_pkg.sv
`default_nettype none

// load/store side of the data cache
package dcache_cpu_pkg;

    localparam int WORD_BYTES     = 4;
    localparam int WORDS_PER_LINE = 8;

    typedef logic [8*WORD_BYTES-1:0]             word_t;
    typedef logic [31:0]                         addr_t;
    typedef logic [WORD_BYTES-1:0]               wmask_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]   word_sel_t;   // word slot inside a line

    // held constant by the CPU until the one-cycle response
    typedef struct packed {
        addr_t   addr;      // byte address
        word_t   wdata;
        wmask_t  wmask;     // byte enables for writes
        logic    read;
        logic    write;
    } cpu_req_t;

    // read and write are never both high on this port

endpackage : dcache_cpu_pkg

`default_nettype wire

//--- dcache_mem_pkg.sv
`default_nettype none

// burst memory side and line transfer between cache and adaptor
package dcache_mem_pkg;

    localparam int LINE_BYTES       = 32;
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);   // byte offset inside a line
    localparam int BURSTS_PER_LINE  = 4;
    localparam int BEAT_IDX_BITS    = $clog2(BURSTS_PER_LINE);

    typedef logic [31:0]               mem_addr_t;
    typedef logic [8*LINE_BYTES-1:0]   line_t;
    typedef logic [LINE_BYTES-1:0]     line_mask_t;   // one bit per line byte
    typedef logic [63:0]               burst_t;
    typedef logic [BEAT_IDX_BITS-1:0]  beat_idx_t;

    typedef struct packed {
        mem_addr_t  addr;       // line aligned
        line_t      wdata;
        logic       read;
        logic       write;
    } line_req_t;

    typedef struct packed {
        mem_addr_t  addr;       // fixed for all beats of a line
        logic       read;
        logic       write;
        burst_t     wdata;
    } bmem_req_t;

endpackage : dcache_mem_pkg

`default_nettype wire

//--- dcache_top.sv
`default_nettype none
`timescale 1ns/10ps

module dcache_top #(
    parameter  int NUM_SETS_LOG2 = 3,
    localparam int TAG_W         = 32 - dcache_mem_pkg::LINE_OFFSET_BITS - NUM_SETS_LOG2
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire dcache_cpu_pkg::cpu_req_t      dmem_req_i,
    output dcache_cpu_pkg::word_t              dmem_rdata_o,
    output logic                               dmem_resp_o,
    output dcache_mem_pkg::bmem_req_t          bmem_req_o,
    input  wire dcache_mem_pkg::burst_t        bmem_rdata_i,
    input  wire                                bmem_resp_i
);

    // lane adapter <-> controller / arrays
    dcache_mem_pkg::line_t       lane_wdata;
    dcache_mem_pkg::line_mask_t  lane_mask;

    // controller -> arrays
    logic [NUM_SETS_LOG2-1:0]    index;
    logic [TAG_W-1:0]            tag_wr;
    logic                        write_line;
    dcache_mem_pkg::line_mask_t  line_mask;
    dcache_mem_pkg::line_t       line_wdata;
    logic                        set_valid;
    logic                        set_dirty;
    logic                        clear_dirty;

    // arrays -> controller, lane adapter
    logic [TAG_W-1:0]            tag_rd;
    logic                        valid;
    logic                        dirty;
    dcache_mem_pkg::line_t       line_rd;

    // controller <-> cacheline adaptor
    dcache_mem_pkg::line_req_t   line_req;
    dcache_mem_pkg::line_t       fill_line;
    logic                        line_resp;

    word_lane_adapter word_lane_adapter_inst (
        .req_i          (dmem_req_i),
        .line_rdata_i   (line_rd),
        .word_o         (dmem_rdata_o),
        .line_wdata_o   (lane_wdata),
        .line_mask_o    (lane_mask)
    );

    dcache_arrays #(
        .NUM_SETS_LOG2  (NUM_SETS_LOG2)
    ) dcache_arrays_inst (
        .clk            (clk),
        .rst            (rst),
        .index_i        (index),
        .tag_i          (tag_wr),
        .write_line_i   (write_line),
        .line_mask_i    (line_mask),
        .line_wdata_i   (line_wdata),
        .set_valid_i    (set_valid),
        .set_dirty_i    (set_dirty),
        .clear_dirty_i  (clear_dirty),
        .tag_o          (tag_rd),
        .valid_o        (valid),
        .dirty_o        (dirty),
        .line_o         (line_rd)
    );

    dcache_controller #(
        .NUM_SETS_LOG2  (NUM_SETS_LOG2)
    ) dcache_controller_inst (
        .clk            (clk),
        .rst            (rst),
        .req_i          (dmem_req_i),
        .lane_wdata_i   (lane_wdata),
        .lane_mask_i    (lane_mask),
        .tag_i          (tag_rd),
        .valid_i        (valid),
        .dirty_i        (dirty),
        .line_i         (line_rd),
        .index_o        (index),
        .tag_o          (tag_wr),
        .write_line_o   (write_line),
        .line_mask_o    (line_mask),
        .line_wdata_o   (line_wdata),
        .set_valid_o    (set_valid),
        .set_dirty_o    (set_dirty),
        .clear_dirty_o  (clear_dirty),
        .line_req_o     (line_req),
        .line_rdata_i   (fill_line),
        .line_resp_i    (line_resp),
        .resp_o         (dmem_resp_o)
    );

    cacheline_adaptor cacheline_adaptor_inst (
        .clk            (clk),
        .rst            (rst),
        .line_req_i     (line_req),
        .line_o         (fill_line),
        .line_resp_o    (line_resp),
        .bmem_req_o     (bmem_req_o),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_resp_i    (bmem_resp_i)
    );

endmodule : dcache_top

`default_nettype wire

//--- tb_bmem_model.sv
`default_nettype none
`timescale 1ns/10ps

module tb_bmem_model (
    input  wire                             clk,
    input  wire                             rst,
    input  wire dcache_mem_pkg::bmem_req_t  req_i,
    output dcache_mem_pkg::burst_t          rdata_o,
    output logic                            resp_o
);

    localparam logic [31:0] FILL_KEY = 32'h5A5A_0000;

    dcache_mem_pkg::burst_t     beats [dcache_mem_pkg::mem_addr_t];   // written beats only
    dcache_mem_pkg::mem_addr_t  beat_addr;
    logic [1:0]                 idle_q;     // idle cycles before the next beat
    logic [1:0]                 beat_q;

    // untouched memory holds its own address xor the key in every word
    function automatic dcache_mem_pkg::burst_t fill_beat(input dcache_mem_pkg::mem_addr_t a);
        return {(a + 32'd4) ^ FILL_KEY, a ^ FILL_KEY};
    endfunction

    assign beat_addr = req_i.addr + {beat_q, 3'b000};   // 8 bytes per beat

    initial begin
        resp_o  = 1'b0;
        rdata_o = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            resp_o  <= 1'b0;
            rdata_o <= '0;
            idle_q  <= '0;
            beat_q  <= '0;
        end else begin
            resp_o <= 1'b0;
            if ((req_i.read || req_i.write) && !resp_o) begin
                if (idle_q == 2'd2) begin
                    idle_q <= '0;
                    beat_q <= beat_q + 1'b1;        // wraps with the line
                    resp_o <= 1'b1;
                    if (req_i.write) begin
                        beats[beat_addr] = req_i.wdata;
                    end else if (beats.exists(beat_addr)) begin
                        rdata_o <= beats[beat_addr];
                    end else begin
                        rdata_o <= fill_beat(beat_addr);
                    end
                end else begin
                    idle_q <= idle_q + 1'b1;
                end
            end
        end
    end

endmodule : tb_bmem_model

`default_nettype wire

//--- tb_dcache_top.sv
`default_nettype none
`timescale 1ns/10ps

module tb_dcache_top;

    localparam int                  NUM_SETS_LOG2 = 3;
    localparam int                  TIMEOUT       = 200;
    localparam dcache_cpu_pkg::addr_t ADDR_A      = 32'h0000_1024;
    localparam dcache_cpu_pkg::addr_t ADDR_B      = 32'h0000_1124;   // same index, other tag

    logic                          clk = 1'b0;
    logic                          rst;
    dcache_cpu_pkg::cpu_req_t      dmem_req;
    dcache_cpu_pkg::word_t         dmem_rdata;
    logic                          dmem_resp;
    dcache_mem_pkg::bmem_req_t     bmem_req;
    dcache_mem_pkg::burst_t        bmem_rdata;
    logic                          bmem_resp;

    int                            errors   = 0;
    int                            rd_beats = 0;
    int                            wr_beats = 0;
    logic                          aborted  = 1'b0;
    logic [15:0]                   lfsr_q;
    dcache_cpu_pkg::word_t         shadow [dcache_cpu_pkg::addr_t];   // expected memory image

    always #20 clk = ~clk;

    dcache_top #(
        .NUM_SETS_LOG2  (NUM_SETS_LOG2)
    ) dcache_top_inst (
        .clk            (clk),
        .rst            (rst),
        .dmem_req_i     (dmem_req),
        .dmem_rdata_o   (dmem_rdata),
        .dmem_resp_o    (dmem_resp),
        .bmem_req_o     (bmem_req),
        .bmem_rdata_i   (bmem_rdata),
        .bmem_resp_i    (bmem_resp)
    );

    tb_bmem_model bmem_model_inst (
        .clk     (clk),
        .rst     (rst),
        .req_i   (bmem_req),
        .rdata_o (bmem_rdata),
        .resp_o  (bmem_resp)
    );

    // beats seen on the burst port
    always @(posedge clk) begin
        if (!rst && bmem_resp && bmem_req.read) begin
            rd_beats <= rd_beats + 1;
        end
        if (!rst && bmem_resp && bmem_req.write) begin
            wr_beats <= wr_beats + 1;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        int k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            bits   = {bits[30:0], lfsr_q[0]};
        end
    endtask

    function automatic dcache_cpu_pkg::word_t expected_word(input dcache_cpu_pkg::addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'h5A5A_0000;
    endfunction

    function automatic dcache_cpu_pkg::word_t merge_bytes(input dcache_cpu_pkg::word_t old_w,
                                                          input dcache_cpu_pkg::word_t new_w,
                                                          input dcache_cpu_pkg::wmask_t m);
        dcache_cpu_pkg::word_t res;
        int b;
        res = old_w;
        for (b = 0; b < 4; b++) begin
            if (m[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input string name, input dcache_cpu_pkg::word_t exp,
                              input dcache_cpu_pkg::word_t act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // holds the request until the one-cycle response
    task automatic issue_req(input dcache_cpu_pkg::addr_t addr, input dcache_cpu_pkg::word_t wdata,
                             input dcache_cpu_pkg::wmask_t wmask, input logic write,
                             output dcache_cpu_pkg::word_t rdata, output int cycles);
        dcache_cpu_pkg::cpu_req_t req;
        logic done;
        rdata  = '0;
        cycles = 0;
        if (aborted) begin
            return;
        end
        req.addr  = addr;
        req.wdata = wdata;
        req.wmask = wmask;
        req.read  = !write;
        req.write = write;
        done      = 1'b0;
        @(posedge clk);
        dmem_req <= req;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;                       // edges waited for the response
            if (dmem_resp) begin
                done  = 1'b1;
                rdata = dmem_rdata;
            end
        end
        dmem_req <= '0;
        if (!done) begin
            errors++;
            aborted = 1'b1;
            $display("No response from the cache for address %h within %0d cycles", addr, TIMEOUT);
        end
    endtask

    task automatic read_word(input string name, input dcache_cpu_pkg::addr_t addr);
        dcache_cpu_pkg::word_t got;
        int cyc;
        issue_req(addr, '0, '0, 1'b0, got, cyc);
        check_word(name, expected_word(addr), got);
    endtask

    task automatic write_word(input dcache_cpu_pkg::addr_t addr, input dcache_cpu_pkg::word_t data,
                              input dcache_cpu_pkg::wmask_t mask);
        dcache_cpu_pkg::word_t got;
        int cyc;
        issue_req(addr, data, mask, 1'b1, got, cyc);
        shadow[addr] = merge_bytes(expected_word(addr), data, mask);
    endtask

    task automatic test_reset();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag("reset resp", 1'b0, dmem_resp);
        check_flag("reset bmem read", 1'b0, bmem_req.read);
        check_flag("reset bmem write", 1'b0, bmem_req.write);
    endtask

    task automatic test_read_miss();
        int rd0;
        rd0 = rd_beats;
        read_word("read miss data", ADDR_A);
        check_word("read miss beats", 32'd4, dcache_cpu_pkg::word_t'(rd_beats - rd0));
    endtask

    task automatic test_hit_partial_write();
        dcache_cpu_pkg::word_t got;
        int cyc;
        int rd0;
        int wr0;
        rd0 = rd_beats;
        wr0 = wr_beats;
        issue_req(ADDR_A, '0, '0, 1'b0, got, cyc);
        check_word("hit read data", expected_word(ADDR_A), got);
        // sampling edge plus the two-cycle hit
        check_word("hit read latency", 32'd3, dcache_cpu_pkg::word_t'(cyc));
        issue_req(ADDR_A, 32'hDEAD_BEEF, 4'b0101, 1'b1, got, cyc);
        shadow[ADDR_A] = merge_bytes(expected_word(ADDR_A), 32'hDEAD_BEEF, 4'b0101);
        check_word("hit write latency", 32'd3, dcache_cpu_pkg::word_t'(cyc));
        read_word("partial write data", ADDR_A);
        check_word("hit read beats", 32'd0, dcache_cpu_pkg::word_t'(rd_beats - rd0));
        check_word("hit write beats", 32'd0, dcache_cpu_pkg::word_t'(wr_beats - wr0));
    endtask

    task automatic test_eviction();
        int wr0;
        wr0 = wr_beats;
        read_word("evicting read data", ADDR_B);
        check_word("victim write beats", 32'd4, dcache_cpu_pkg::word_t'(wr_beats - wr0));
        read_word("victim reload data", ADDR_A);   // comes back from memory
    endtask

    task automatic test_random_traffic();
        logic [31:0] op;
        logic [31:0] sel;
        logic [31:0] data;
        logic [31:0] mask;
        dcache_cpu_pkg::addr_t addr;
        int i;
        for (i = 0; i < 200; i++) begin
            draw_bits(1, op);
            draw_bits(7, sel);              // 16 lines, 8 words each
            draw_bits(32, data);
            draw_bits(4, mask);
            addr = 32'h0000_2000 + {sel[6:0], 2'b00};
            if (op[0]) begin
                write_word(addr, data, mask[3:0]);
            end else begin
                read_word("random read", addr);
            end
        end
    endtask

    initial begin
        rst      <= 1'b1;
        dmem_req <= '0;
        lfsr_q    = 16'd17;
        test_reset();
        test_read_miss();
        test_hit_partial_write();
        test_eviction();
        test_random_traffic();
        repeat (2) @(posedge clk);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_dcache_top

`default_nettype wire

//--- word_lane_adapter.sv
`default_nettype none
`timescale 1ns/10ps

module word_lane_adapter (
    input  wire dcache_cpu_pkg::cpu_req_t     req_i,
    input  wire dcache_mem_pkg::line_t        line_rdata_i,
    output dcache_cpu_pkg::word_t             word_o,
    output dcache_mem_pkg::line_t             line_wdata_o,
    output dcache_mem_pkg::line_mask_t        line_mask_o
);

    dcache_cpu_pkg::word_sel_t   word_sel;
    dcache_mem_pkg::line_mask_t  lane0_mask;    // word mask sitting in lane 0

    assign word_sel = req_i.addr[4:2];          // word slot within the line

    // write data goes to every lane, the mask picks the real one
    assign line_wdata_o = {dcache_cpu_pkg::WORDS_PER_LINE{req_i.wdata}};

    assign lane0_mask  = dcache_mem_pkg::line_mask_t'(req_i.wmask);
    assign line_mask_o = lane0_mask << {word_sel, 2'b00};   // 4 bytes per lane

    // addressed word out of the stored line
    assign word_o = line_rdata_i[{word_sel, 5'b00000} +: $bits(dcache_cpu_pkg::word_t)];

endmodule : word_lane_adapter

`default_nettype wire
